// ==== rtl/rvPkg.sv ====
`default_nettype none

package rvPkg;

	localparam int xlen = 32;
	localparam logic [xlen-1:0] resetPc = 32'h0000_0000;
	localparam int dmemWords = 256;
	localparam int dmemAddrBits = $clog2(dmemWords);

	// the one system instruction that is decoded
	localparam logic [xlen-1:0] ebreakInst = 32'h0010_0073;

	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opImm    = 7'b0010011,
		opReg    = 7'b0110011,
		opSystem = 7'b1110011
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd   = 4'd0,
		aluSub   = 4'd1,
		aluAnd   = 4'd2,
		aluOr    = 4'd3,
		aluXor   = 4'd4,
		aluSll   = 4'd5,
		aluSrl   = 4'd6,
		aluSra   = 4'd7,
		aluSlt   = 4'd8,
		aluSltu  = 4'd9,
		aluPassB = 4'd10
	} aluOpE;

	typedef enum logic [1:0] {
		wbAlu     = 2'd0,
		wbMem     = 2'd1,
		wbPcPlus4 = 2'd2
	} wbSelE;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		sizeByte = 2'd0,
		sizeHalf = 2'd1,
		sizeWord = 2'd2
	} memSizeE;

	typedef struct packed {
		aluOpE aluOp;
		logic aluSrcImm;
		logic aluSrcPc;
		logic regWrite;
		wbSelE wbSel;
		logic memRead;
		logic memWrite;
		memSizeE memSize;
		logic memUnsigned;
		logic branch;
		logic [2:0] branchFunct;
		logic jump;
		logic jumpReg;
		logic ebreak;
	} ctrlT;

	typedef struct packed {
		logic read;
		logic write;
		memSizeE size;
		logic unsignedLoad;
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
	} memReqT;

endpackage

`default_nettype wire

// ==== rtl/rvDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvDecoder (
	input wire logic [rvPkg::xlen-1:0] inst,
	output rvPkg::ctrlT ctrl,
	output logic [rvPkg::xlen-1:0] imm
);
	import rvPkg::*;

	opcodeE opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [xlen-1:0] immI;
	logic [xlen-1:0] immS;
	logic [xlen-1:0] immB;
	logic [xlen-1:0] immU;
	logic [xlen-1:0] immJ;

	function automatic aluOpE aluFromFunct(
		input logic [2:0] f3,
		input logic alt,
		input logic isReg
	);
		aluOpE op;
		case (f3)
			3'b000: op = (isReg && alt) ? aluSub : aluAdd;
			3'b001: op = aluSll;
			3'b010: op = aluSlt;
			3'b011: op = aluSltu;
			3'b100: op = aluXor;
			3'b101: op = alt ? aluSra : aluSrl;
			3'b110: op = aluOr;
			default: op = aluAnd;
		endcase
		return op;
	endfunction

	assign opcode = opcodeE'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		ctrl = '0;
		imm = '0;
		case (opcode)
			opLui: begin
				imm = immU;
				ctrl.aluOp = aluPassB;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opAuipc: begin
				imm = immU;
				ctrl.aluSrcPc = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opJal: begin
				imm = immJ;
				ctrl.jump = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = wbPcPlus4;
			end
			opJalr: begin
				// target is rs1+imm through the ALU
				imm = immI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.jumpReg = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = wbPcPlus4;
			end
			opBranch: begin
				imm = immB;
				ctrl.branch = (funct3[2:1] != 2'b01);
				ctrl.branchFunct = funct3;
			end
			opLoad: begin
				imm = immI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = (funct3[1:0] != 2'b11) && (funct3[2:1] != 2'b11);
				ctrl.regWrite = ctrl.memRead;
				ctrl.wbSel = wbMem;
				ctrl.memSize = memSizeE'(funct3[1:0]);
				ctrl.memUnsigned = funct3[2];
			end
			opStore: begin
				imm = immS;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = !funct3[2] && (funct3[1:0] != 2'b11);
				ctrl.memSize = memSizeE'(funct3[1:0]);
			end
			opImm: begin
				imm = immI;
				ctrl.aluOp = aluFromFunct(funct3, funct7[5], 1'b0);
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opReg: begin
				ctrl.aluOp = aluFromFunct(funct3, funct7[5], 1'b1);
				ctrl.regWrite = 1'b1;
			end
			opSystem: begin
				ctrl.ebreak = (inst == ebreakInst);
			end
			default: begin
				// unsupported opcode runs as a no-op
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/rvRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvRegFile (
	input wire logic clk,
	input wire logic rstN,
	input wire logic we,
	input wire logic [4:0] rs1,
	input wire logic [4:0] rs2,
	input wire logic [4:0] rd,
	input wire logic [rvPkg::xlen-1:0] wdata,
	output logic [rvPkg::xlen-1:0] rdata1,
	output logic [rvPkg::xlen-1:0] rdata2
);
	import rvPkg::*;

	// x0 has no storage
	logic [xlen-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rd != 5'd0)) begin
			regs[rd] <= wdata;
		end
	end

	assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/rvAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvAlu (
	input wire rvPkg::aluOpE op,
	input wire logic [rvPkg::xlen-1:0] a,
	input wire logic [rvPkg::xlen-1:0] b,
	input wire logic [2:0] branchFunct,
	output logic [rvPkg::xlen-1:0] result,
	output logic taken
);
	import rvPkg::*;

	logic equal;
	logic lessSigned;
	logic lessUnsigned;

	// compares shared by slt/sltu and the branches
	assign equal = (a == b);
	assign lessSigned = ($signed(a) < $signed(b));
	assign lessUnsigned = (a < b);

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluSll: result = a << b[4:0];
			aluSrl: result = a >> b[4:0];
			aluSra: result = $signed(a) >>> b[4:0];
			aluSlt: result = {{(xlen-1){1'b0}}, lessSigned};
			aluSltu: result = {{(xlen-1){1'b0}}, lessUnsigned};
			aluPassB: result = b;
			default: result = '0;
		endcase
	end

	always_comb begin
		case (branchFunct)
			3'b000: taken = equal;
			3'b001: taken = !equal;
			3'b100: taken = lessSigned;
			3'b101: taken = !lessSigned;
			3'b110: taken = lessUnsigned;
			3'b111: taken = !lessUnsigned;
			default: taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/rvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvCore (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [rvPkg::xlen-1:0] inst,
	output logic [rvPkg::xlen-1:0] pc,
	output rvPkg::memReqT memReq,
	input wire logic [rvPkg::xlen-1:0] memRdata,
	output logic halted
);
	import rvPkg::*;

	ctrlT ctrl;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rs1Data;
	logic [xlen-1:0] rs2Data;
	logic [xlen-1:0] srcA;
	logic [xlen-1:0] srcB;
	logic [xlen-1:0] aluResult;
	logic taken;
	logic [xlen-1:0] pcPlus4;
	logic [xlen-1:0] pcTarget;
	logic [xlen-1:0] nextPc;
	logic [xlen-1:0] wbData;
	logic regWe;

	rvDecoder rvDecoder_i (
		.inst (inst),
		.ctrl (ctrl),
		.imm  (imm)
	);

	rvRegFile rvRegFile_i (
		.clk    (clk),
		.rstN   (rstN),
		.we     (regWe),
		.rs1    (inst[19:15]),
		.rs2    (inst[24:20]),
		.rd     (inst[11:7]),
		.wdata  (wbData),
		.rdata1 (rs1Data),
		.rdata2 (rs2Data)
	);

	rvAlu rvAlu_i (
		.op          (ctrl.aluOp),
		.a           (srcA),
		.b           (srcB),
		.branchFunct (ctrl.branchFunct),
		.result      (aluResult),
		.taken       (taken)
	);

	assign srcA = ctrl.aluSrcPc ? pc : rs1Data;
	assign srcB = ctrl.aluSrcImm ? imm : rs2Data;

	assign pcPlus4 = pc + 32'd4;
	assign pcTarget = pc + imm;

	always_comb begin
		if (ctrl.jumpReg)
			nextPc = {aluResult[xlen-1:1], 1'b0};
		else if (ctrl.jump || (ctrl.branch && taken))
			nextPc = pcTarget;
		else
			nextPc = pcPlus4;
	end

	always_comb begin
		case (ctrl.wbSel)
			wbMem: wbData = memRdata;
			wbPcPlus4: wbData = pcPlus4;
			default: wbData = aluResult;
		endcase
	end

	// no architectural writes once halted
	assign regWe = ctrl.regWrite && !halted;

	assign memReq.read = ctrl.memRead;
	assign memReq.write = ctrl.memWrite && !halted;
	assign memReq.size = ctrl.memSize;
	assign memReq.unsignedLoad = ctrl.memUnsigned;
	assign memReq.addr = aluResult;
	assign memReq.wdata = rs2Data;

	// pc stays on the ebreak
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= resetPc;
			halted <= 1'b0;
		end else begin
			if (!halted && !ctrl.ebreak)
				pc <= nextPc;
			if (ctrl.ebreak)
				halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rvDataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvDataMem (
	input wire logic clk,
	input wire rvPkg::memReqT req,
	output logic [rvPkg::xlen-1:0] rdata
);
	import rvPkg::*;

	logic [xlen-1:0] mem [dmemWords];
	logic [dmemAddrBits-1:0] wordIdx;
	logic [3:0] byteEn;
	logic [xlen-1:0] laneData;
	logic [xlen-1:0] memWord;
	logic [7:0] loadByte;
	logic [15:0] loadHalf;
	logic [xlen-1:0] loadVal;

	assign wordIdx = req.addr[dmemAddrBits+1:2];
	assign memWord = mem[wordIdx];

	// store data replicated across lanes and the enables pick the target bytes
	always_comb begin
		case (req.size)
			sizeByte: begin
				byteEn = 4'b0001 << req.addr[1:0];
				laneData = {4{req.wdata[7:0]}};
			end
			sizeHalf: begin
				byteEn = req.addr[1] ? 4'b1100 : 4'b0011;
				laneData = {2{req.wdata[15:0]}};
			end
			default: begin
				byteEn = 4'b1111;
				laneData = req.wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (req.write) begin
			for (int i = 0; i < 4; i++) begin
				if (byteEn[i])
					mem[wordIdx][i*8 +: 8] <= laneData[i*8 +: 8];
			end
		end
	end

	assign loadByte = memWord[{req.addr[1:0], 3'b000} +: 8];
	assign loadHalf = req.addr[1] ? memWord[31:16] : memWord[15:0];

	always_comb begin
		case (req.size)
			sizeByte: loadVal = {{24{!req.unsignedLoad && loadByte[7]}}, loadByte};
			sizeHalf: loadVal = {{16{!req.unsignedLoad && loadHalf[15]}}, loadHalf};
			default: loadVal = memWord;
		endcase
	end

	assign rdata = req.read ? loadVal : '0;

endmodule

`default_nettype wire

// ==== rtl/rvSoc.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvSoc (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [rvPkg::xlen-1:0] inst,
	output logic [rvPkg::xlen-1:0] pc,
	output rvPkg::memReqT memReq,
	output logic [rvPkg::xlen-1:0] rdata,
	output logic halted
);

	rvCore rvCore_i (
		.clk      (clk),
		.rstN     (rstN),
		.inst     (inst),
		.pc       (pc),
		.memReq   (memReq),
		.memRdata (rdata),
		.halted   (halted)
	);

	// load data returns in the same cycle
	rvDataMem rvDataMem_i (
		.clk   (clk),
		.req   (memReq),
		.rdata (rdata)
	);

endmodule

`default_nettype wire

// ==== verif/rvSoc_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvSoc_asserts (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [rvPkg::xlen-1:0] pc,
	input wire rvPkg::memReqT memReq,
	input wire logic halted
);

	int failCount = 0;

	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else begin
			$error("pc is not word aligned");
			failCount++;
		end

	rwExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(memReq.read && memReq.write))
		else begin
			$error("read and write set together");
			failCount++;
		end

	noWriteHalted: assert property (@(posedge clk) disable iff (!rstN)
		halted |-> !memReq.write)
		else begin
			$error("memory write while halted");
			failCount++;
		end

	// only reset clears halted
	haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
		else begin
			$error("halted fell without reset");
			failCount++;
		end

endmodule

bind rvCore rvSoc_asserts rvSoc_asserts_i (.*);

`default_nettype wire

// ==== verif/rvSocTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvSocTb;
	import rvPkg::*;

	logic clk;
	logic rstN;
	logic [xlen-1:0] inst;
	logic [xlen-1:0] pc;
	memReqT memReq;
	logic [xlen-1:0] rdata;
	logic halted;

	rvSoc rvSoc_i (
		.clk    (clk),
		.rstN   (rstN),
		.inst   (inst),
		.pc     (pc),
		.memReq (memReq),
		.rdata  (rdata),
		.halted (halted)
	);

	logic [31:0] rom [256];
	int progLen;
	int secEnd [3];
	int seed;
	logic running;
	int cycles;
	int limit;
	int resetEdges;
	int errors;
	int secErr [5];
	int curSec;
	string testNames [5] = '{"reset state", "load and store", "branch and jump",
		"alu random", "halt on ebreak"};
	int rF7 [10] = '{0, 32, 0, 0, 0, 0, 0, 32, 0, 0};
	int rF3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
	int iF3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};

	// ISA model state
	logic [31:0] mReg [32];
	logic [31:0] mPc;
	logic mHalted;
	logic [7:0] mMem [bit [31:0]];
	logic expRead;
	logic expWrite;
	logic [1:0] expSize;
	logic expUns;
	logic [31:0] expAddr;
	logic [31:0] expWdata;
	logic [31:0] expRdata;

	function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] encI(int imm, int rs1, int f3, int rd, int op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] encS(int imm, int rs2, int rs1, int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] encB(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] encU(int imm, int rd, int op);
		return {imm[19:0], rd[4:0], op[6:0]};
	endfunction

	task automatic put(input logic [31:0] w);
		rom[progLen[7:0]] = w;
		progLen++;
	endtask

	// alt selects sub and sra
	function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchRef(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [7:0] memByte(logic [31:0] addr);
		if (mMem.exists(addr))
			return mMem[addr];
		return 8'hxx;
	endfunction

	function automatic logic [31:0] loadRef(logic [31:0] addr, logic [2:0] f3);
		logic [7:0] b0;
		logic [7:0] b1;
		b0 = memByte(addr);
		b1 = memByte(addr + 32'd1);
		case (f3[1:0])
			2'd0: return {{24{!f3[2] && b0[7]}}, b0};
			2'd1: return {{16{!f3[2] && b1[7]}}, b1, b0};
			default: return {memByte(addr + 32'd3), memByte(addr + 32'd2), b1, b0};
		endcase
	endfunction

	// steps one instruction and sets the expected bus values
	task automatic modelStep(input logic [31:0] in);
		logic [2:0] f3;
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] iI;
		logic [31:0] iS;
		logic [31:0] iB;
		logic [31:0] iU;
		logic [31:0] iJ;
		logic [31:0] nPc;
		logic [31:0] res;
		logic wr;
		logic haltNow;
		f3 = in[14:12];
		rd = in[11:7];
		a = mReg[in[19:15]];
		b = mReg[in[24:20]];
		iI = {{20{in[31]}}, in[31:20]};
		iS = {{20{in[31]}}, in[31:25], in[11:7]};
		iB = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
		iU = {in[31:12], 12'h000};
		iJ = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
		nPc = mPc + 32'd4;
		res = '0;
		wr = 1'b0;
		haltNow = 1'b0;
		expRead = 1'b0;
		expWrite = 1'b0;
		expSize = 2'd0;
		expUns = 1'b0;
		expAddr = '0;
		expWdata = '0;
		expRdata = '0;
		case (in[6:0])
			7'h37: begin
				res = iU;
				wr = 1'b1;
			end
			7'h17: begin
				res = mPc + iU;
				wr = 1'b1;
			end
			7'h6f: begin
				res = mPc + 32'd4;
				wr = 1'b1;
				nPc = mPc + iJ;
			end
			7'h67: begin
				res = mPc + 32'd4;
				wr = 1'b1;
				nPc = (a + iI) & ~32'd1;
			end
			7'h63: begin
				if (f3[2:1] != 2'b01 && branchRef(f3, a, b))
					nPc = mPc + iB;
			end
			7'h03: begin
				if (f3[1:0] != 2'b11 && f3[2:1] != 2'b11) begin
					expRead = 1'b1;
					expAddr = a + iI;
					expSize = f3[1:0];
					expUns = f3[2];
					expRdata = loadRef(expAddr, f3);
					res = expRdata;
					wr = 1'b1;
				end
			end
			7'h23: begin
				if (!f3[2] && f3[1:0] != 2'b11) begin
					expWrite = 1'b1;
					expAddr = a + iS;
					expSize = f3[1:0];
					expWdata = b;
				end
			end
			7'h13: begin
				res = aluRef(f3, f3 == 3'd5 && in[30], a, iI);
				wr = 1'b1;
			end
			7'h33: begin
				res = aluRef(f3, in[30], a, b);
				wr = 1'b1;
			end
			7'h73: haltNow = (in == 32'h0010_0073);
			default: begin
			end
		endcase
		if (mHalted) begin
			expWrite = 1'b0;
		end else if (haltNow) begin
			mHalted = 1'b1;
		end else begin
			if (wr && rd != 5'd0)
				mReg[rd] = res;
			if (expWrite) begin
				for (int i = 0; i < (1 << expSize); i++)
					mMem[expAddr + i] = expWdata[8*i +: 8];
			end
			mPc = nPc;
		end
	endtask

	function automatic int sectionOf(logic [31:0] modelPc);
		int idx;
		idx = {24'b0, modelPc[9:2]};
		if (idx < secEnd[0])
			return 1;
		if (idx < secEnd[1])
			return 2;
		if (idx < secEnd[2])
			return 3;
		return 4;
	endfunction

	task automatic logError(input string msg);
		$display("ERR %0t %s", $time, msg);
		errors++;
		secErr[curSec]++;
	endtask

	task automatic reportTest(input int s);
		if (secErr[s] == 0)
			$display("test %s: ok", testNames[s]);
		else
			$display("test %s: failed with %0d errors", testNames[s], secErr[s]);
	endtask

	task automatic buildProgram();
		int r;
		int off;
		int ldF3 [9] = '{0, 4, 1, 5, 2, 0, 5, 2, 4};
		int ldAddr [9] = '{'h201, 'h201, 'h206, 'h206, 'h204, 'h203, 'h200, 'h200, 'h207};
		int bF3 [12] = '{0, 1, 0, 1, 4, 5, 4, 5, 6, 7, 6, 7};
		int bA [12] = '{2, 2, 1, 1, 1, 1, 2, 2, 1, 1, 2, 2};
		int bB [12] = '{3, 3, 2, 2, 2, 2, 1, 1, 2, 2, 1, 1};
		for (int i = 0; i < 256; i++)
			rom[i] = '0;
		progLen = 0;
		// x8 has the sign bits of byte and half set
		r = $random(seed);
		put(encU(r >> 12, 7, 'h37));
		put(encI(r, 7, 0, 7, 'h13));
		put(encI(-128, 0, 0, 8, 'h13));
		put(encS('h200, 7, 0, 2));
		put(encS('h204, 7, 0, 2));
		put(encS('h201, 8, 0, 0));
		put(encS('h206, 8, 0, 1));
		for (int k = 0; k < 9; k++) begin
			put(encI(ldAddr[k], 0, ldF3[k], 9, 'h03));
			put(encS('h220 + 4 * k, 9, 0, 2));
		end
		secEnd[0] = progLen;
		// each branch has a skip slot that counts in x20
		put(encI(-1, 0, 0, 1, 'h13));
		put(encI(1, 0, 0, 2, 'h13));
		put(encI(1, 0, 0, 3, 'h13));
		put(encI(0, 0, 0, 20, 'h13));
		for (int k = 0; k < 12; k++) begin
			put(encB(8, bB[k], bA[k], bF3[k]));
			put(encI(1, 20, 0, 20, 'h13));
		end
		put({20'h00800, 5'd21, 7'h6f});
		put(encI(1, 20, 0, 20, 'h13));
		put(encU(0, 22, 'h17));
		put(encI(13, 22, 0, 23, 'h67));
		put(encI(1, 20, 0, 20, 'h13));
		put(encS('h300, 20, 0, 2));
		put(encS('h304, 21, 0, 2));
		put(encS('h308, 23, 0, 2));
		secEnd[1] = progLen;
		off = 'h100;
		for (int it = 0; it < 3; it++) begin
			r = $random(seed);
			put(encU(r >> 12, 1, 'h37));
			put(encI(r, 1, 0, 1, 'h13));
			r = $random(seed);
			put(encU(r >> 12, 2, 'h37));
			put(encI(r, 2, 0, 2, 'h13));
			for (int k = 0; k < 10; k++) begin
				put(encR(rF7[k], 2, 1, rF3[k], 5));
				put(encS(off, 5, 0, 2));
				off += 4;
			end
			for (int k = 0; k < 9; k++) begin
				r = $random(seed);
				if (k >= 6)
					r = (k == 8) ? ('h400 | (r & 31)) : (r & 31);
				put(encI(r, 1, iF3[k], 6, 'h13));
				put(encS(off, 6, 0, 2));
				off += 4;
			end
			// x0 must stay zero
			put(encR(0, 2, 1, 0, 0));
			put(encS(off, 0, 0, 2));
			off += 4;
			put(encU($random(seed), 5, 'h17));
			put(encS(off, 5, 0, 2));
			off += 4;
		end
		secEnd[2] = progLen;
		put(32'h0010_0073);
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// compare at the rising edge against the model
	always @(posedge clk) begin
		if (!rstN) begin
			mPc = resetPc;
			mHalted = 1'b0;
			for (int i = 0; i < 32; i++)
				mReg[i] = '0;
			resetEdges++;
			if (resetEdges == 16) begin
				curSec = 0;
				if (pc !== resetPc || halted !== 1'b0)
					logError($sformatf("after reset pc %h halted %b", pc, halted));
				if (memReq.read !== 1'b0 || memReq.write !== 1'b0)
					logError("memory request active during reset");
				reportTest(0);
				curSec = 1;
			end
		end else if (running) begin
			if (sectionOf(mPc) != curSec) begin
				reportTest(curSec);
				curSec = sectionOf(mPc);
			end
			if (pc !== mPc)
				logError($sformatf("pc %h expected %h", pc, mPc));
			if (halted !== mHalted)
				logError($sformatf("halted %b expected %b", halted, mHalted));
			modelStep(inst);
			if (memReq.read !== expRead || memReq.write !== expWrite)
				logError($sformatf("read/write %b%b expected %b%b at pc %h",
					memReq.read, memReq.write, expRead, expWrite, pc));
			if ((expRead || expWrite) && (memReq.addr !== expAddr || memReq.size !== expSize))
				logError($sformatf("addr %h expected %h", memReq.addr, expAddr));
			if (expWrite && memReq.wdata !== expWdata)
				logError($sformatf("wdata %h expected %h", memReq.wdata, expWdata));
			if (expRead && memReq.unsignedLoad !== expUns)
				logError("unsignedLoad differs from the load type");
			if (rdata !== expRdata)
				logError($sformatf("rdata %h expected %h", rdata, expRdata));
		end
	end

	always @(posedge clk) begin
		if (running) begin
			cycles++;
			if (cycles > limit) begin
				$display("timeout: no halt within %0d cycles", limit);
				$display("Simulation finished: FAIL");
				$finish;
			end
		end
	end

	initial begin
		int haltCycles;
		int nFail;
		int assertFails;
		seed = 32'h25a3_75f2;
		haltCycles = 0;
		nFail = 0;
		running = 1'b0;
		inst = '0;
		rstN = 1'b0;
		buildProgram();
		limit = 2 * progLen + 100;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		running = 1'b1;
		inst = rom[pc[9:2]];
		// sw x1 keeps coming after the halt
		while (haltCycles <= 6) begin
			@(negedge clk);
			if (halted === 1'b1)
				haltCycles++;
			inst = (halted === 1'b1) ? encS('h310, 1, 0, 2) : rom[pc[9:2]];
		end
		running = 1'b0;
		reportTest(curSec);
		assertFails = rvSoc_i.rvCore_i.rvSoc_asserts_i.failCount;
		if (assertFails != 0)
			$display("%0d assertion failures in the core", assertFails);
		for (int s = 0; s < 5; s++) begin
			if (secErr[s] != 0)
				nFail++;
		end
		$display("tests run 5, passed %0d, failed %0d, errors %0d", 5 - nFail, nFail, errors);
		if (errors == 0 && assertFails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/rvPkg.sv
rtl/rvDecoder.sv
rtl/rvRegFile.sv
rtl/rvAlu.sv
rtl/rvCore.sv
rtl/rvDataMem.sv
rtl/rvSoc.sv
verif/rvSoc_asserts.sv
verif/rvSocTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module rvSocTb -f all.f
out=$(./obj_dir/VrvSocTb)
echo "$out"
if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
else
	exit 1
fi
